// ==== pool_engine.f ====
pool_pkg.sv
pool_fetch.sv
atom_fifo.sv
pool_reduce.sv
pool_engine.sv
tb_dma_model.sv
tb_pool_engine.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pool_engine
BUILD_DIR ?= build
FILELIST  ?= pool_engine.f
VFLAGS    ?= --binary --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulator is the verdict
run: $(SIM)
	$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_pool_engine.sv ====
`timescale 1ns/1ps

module tb_pool_engine;

	import pool_pkg::*;

	localparam int    MEM_AW     = 10;
	localparam int    RST_CYCLES = 8;
	localparam int    NUM_JOBS   = 8;
	localparam addr_t STRAY_DST  = 30'd900;  // Target of the start pulsed while busy

	typedef struct packed {
		pool_op_e              op;
		logic [WIN_LOG2_W-1:0] win_log2;
		logic [NWIN_W-1:0]     num_windows;
		addr_t                 src;
		addr_t                 dst;
		logic                  restart;  // Pulse a second start while busy
	} job_t;

	// op, win_log2, windows, src, dst, restart
	localparam job_t JOBS [NUM_JOBS] = '{
		'{OP_MPOOL, 2'd0, 8'd3, 30'd0,   30'd512, 1'b0},
		'{OP_MPOOL, 2'd1, 8'd4, 30'd16,  30'd528, 1'b0},
		'{OP_MPOOL, 2'd2, 8'd3, 30'd48,  30'd544, 1'b0},
		'{OP_MPOOL, 2'd3, 8'd2, 30'd96,  30'd560, 1'b1},
		'{OP_APOOL, 2'd0, 8'd2, 30'd160, 30'd576, 1'b0},
		'{OP_APOOL, 2'd1, 8'd3, 30'd200, 30'd592, 1'b0},
		'{OP_APOOL, 2'd2, 8'd2, 30'd240, 30'd608, 1'b0},
		'{OP_APOOL, 2'd3, 8'd4, 30'd300, 30'd640, 1'b1}  // Sums overflow 16 bits
	};

	logic                  clk;
	logic                  rst;
	logic                  start;
	pool_op_e              op;
	logic [WIN_LOG2_W-1:0] win_log2;
	logic [NWIN_W-1:0]     num_windows;
	addr_t                 src_addr;
	addr_t                 dst_addr;
	word_t                 rd_data;
	logic                  rd_we;
	logic                  rd_req;
	addr_t                 rd_addr;
	logic                  wr_ready;
	logic                  wr_valid;
	addr_t                 wr_addr;
	word_t                 wr_data;
	logic                  busy;
	logic                  done;
	addr_t                 rd_seen [$];    // Burst addresses of the current job
	int                    done_seen = 0;

	pool_engine i_pool_engine (
		.clk(clk), .rst(rst), .i_start(start), .i_op(op), .i_win_log2(win_log2),
		.i_num_windows(num_windows), .i_src_addr(src_addr), .i_dst_addr(dst_addr),
		.i_rd_data(rd_data), .i_rd_we(rd_we), .o_rd_req(rd_req), .o_rd_addr(rd_addr),
		.i_wr_ready(wr_ready), .o_wr_valid(wr_valid), .o_wr_addr(wr_addr),
		.o_wr_data(wr_data), .o_busy(busy), .o_done(done)
	);

	tb_dma_model #(.MEM_AW(MEM_AW)) i_dma (
		.clk(clk), .rst(rst), .i_rd_req(rd_req), .i_rd_addr(rd_addr),
		.o_rd_data(rd_data), .o_rd_we(rd_we), .i_wr_valid(wr_valid),
		.i_wr_addr(wr_addr), .i_wr_data(wr_data), .o_wr_ready(wr_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	always @(posedge clk) begin
		if (!rst && rd_req)
			rd_seen.push_back(rd_addr);
		if (!rst && done)
			done_seen++;
	end

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			report_error($sformatf("mismatch %s: got 'h%h, expected 'h%h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
			report_error($sformatf("mismatch %s: got 'h%h, expected 'h%h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_error($sformatf("mismatch %s: got 'h%h, expected 'h%h", name, got, exp));
	endtask

	function automatic int total_beats();
		int n;
		n = 0;
		for (int j = 0; j < NUM_JOBS; j++)
			n += LANES * (int'(JOBS[j].num_windows) << JOBS[j].win_log2);
		return n;
	endfunction

	// Max or truncated mean of one lane over the atoms of window w
	function automatic word_t expected_word(input job_t row, input int w, input int l);
		logic [SUM_W-1:0] acc;
		word_t            v;
		int               len;
		int               base;
		len  = 1 << row.win_log2;
		base = int'(row.src) + w * len * LANES;
		acc  = '0;
		for (int a = 0; a < len; a++) begin
			v = i_dma.mem[MEM_AW'(base + a * LANES + l)];
			if (row.op == OP_APOOL)
				acc = acc + SUM_W'(v);
			else if (a == 0 || SUM_W'(v) > acc)
				acc = SUM_W'(v);
		end
		if (row.op == OP_APOOL)
			return word_t'(acc >> row.win_log2);
		return word_t'(acc);
	endfunction

	task automatic check_idle();
		check_flag("o_rd_req", rd_req, 1'b0);
		check_flag("o_wr_valid", wr_valid, 1'b0);
		check_flag("o_busy", busy, 1'b0);
		check_flag("o_done", done, 1'b0);
	endtask

	task automatic run_job(input job_t row);
		int atoms;
		int done_before;
		atoms       = int'(row.num_windows) << row.win_log2;
		done_before = done_seen;
		rd_seen.delete();
		@(negedge clk);
		start       = 1'b1;
		op          = row.op;
		win_log2    = row.win_log2;
		num_windows = row.num_windows;
		src_addr    = row.src;
		dst_addr    = row.dst;
		@(negedge clk);
		start = 1'b0;
		check_flag("o_busy", busy, 1'b1);  // Busy on the cycle after acceptance
		if (row.restart) begin
			start    = 1'b1;  // Must be ignored while busy
			dst_addr = STRAY_DST;
			@(negedge clk);
			start = 1'b0;
		end
		while (!done)
			@(negedge clk);
		check_flag("o_busy", busy, 1'b0);  // Falls with the done pulse
		// Last transfer lands on the same edge that raises done
		if (i_dma.wr_addr_q.size() != int'(row.num_windows) * LANES)
			report_error($sformatf("o_done came after %0d of %0d writes",
				i_dma.wr_addr_q.size(), int'(row.num_windows) * LANES));
		repeat (10) @(negedge clk);  // Room for a stray write or second done
		if (done_seen != done_before + 1)
			report_error($sformatf("o_done pulsed %0d times for one job",
				done_seen - done_before));
		if (i_dma.wr_addr_q.size() != int'(row.num_windows) * LANES)
			report_error($sformatf("job wrote %0d words instead of %0d",
				i_dma.wr_addr_q.size(), int'(row.num_windows) * LANES));
		for (int w = 0; w < int'(row.num_windows); w++) begin
			for (int l = 0; l < LANES; l++) begin
				check_addr("o_wr_addr", i_dma.wr_addr_q.pop_front(),
					addr_t'(int'(row.dst) + w * LANES + l));
				check_word("o_wr_data", i_dma.wr_data_q.pop_front(), expected_word(row, w, l));
			end
		end
		if (rd_seen.size() != atoms)
			report_error($sformatf("job issued %0d read bursts instead of %0d",
				rd_seen.size(), atoms));
		for (int k = 0; k < atoms; k++)
			check_addr("o_rd_addr", rd_seen.pop_front(), addr_t'(int'(row.src) + k * LANES));
	endtask

	initial begin : stimulus
		rst         = 1'b1;
		start       = 1'b0;
		op          = OP_MPOOL;
		win_log2    = '0;
		num_windows = '0;
		src_addr    = '0;
		dst_addr    = '0;
		repeat (RST_CYCLES) begin
			@(negedge clk);
			check_idle();
		end
		rst = 1'b0;
		repeat (2) begin
			@(negedge clk);
			check_idle();  // Still quiet with no job
		end
		for (int j = 0; j < NUM_JOBS; j++)
			run_job(JOBS[j]);
		$display("All checks passed");
		$finish;
	end

	initial begin : watchdog
		int limit;
		limit = 200 * total_beats() + RST_CYCLES + 20 * NUM_JOBS;
		repeat (limit) @(posedge clk);
		report_error($sformatf("run timed out after %0d cycles", limit));
	end

endmodule

// ==== tb_dma_model.sv ====
`timescale 1ns/1ps

module tb_dma_model #(
	parameter int MEM_AW = 10  // Word address bits held by the model
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            i_rd_req,
	input  pool_pkg::addr_t i_rd_addr,
	output pool_pkg::word_t o_rd_data,
	output logic            o_rd_we,
	input  logic            i_wr_valid,
	input  pool_pkg::addr_t i_wr_addr,
	input  pool_pkg::word_t i_wr_data,
	output logic            o_wr_ready
);

	import pool_pkg::*;

	word_t       mem [1 << MEM_AW];  // Feature-map memory
	addr_t       rd_pending [$];     // Bursts not yet answered
	addr_t       wr_addr_q [$];      // Write transfers in arrival order
	word_t       wr_data_q [$];
	logic [31:0] rd_rng;             // Read latency and gaps
	logic [31:0] wr_rng;             // Write ready pattern

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	initial begin : fill
		logic [31:0] s;
		s = 32'hd471;
		for (int a = 0; a < (1 << MEM_AW); a++) begin
			s = xorshift(s);
			mem[MEM_AW'(a)] = s[31:16] ^ s[15:0];  // Fold both halves
		end
		rd_rng = xorshift(s);
		wr_rng = xorshift(rd_rng);
	end

	// Requests are taken on the rising edge
	always @(posedge clk) begin
		if (!rst && i_rd_req)
			rd_pending.push_back(i_rd_addr);
		if (!rst && i_wr_valid && o_wr_ready) begin
			wr_addr_q.push_back(i_wr_addr);
			wr_data_q.push_back(i_wr_data);
		end
	end

	// Beats go out on the falling edge
	initial begin : serve_reads
		addr_t base;
		o_rd_we   = 1'b0;
		o_rd_data = '0;
		forever begin
			@(negedge clk);
			o_rd_we = 1'b0;
			if (rd_pending.size() != 0) begin
				base   = rd_pending.pop_front();
				rd_rng = xorshift(rd_rng);
				repeat (rd_rng % 4) @(negedge clk);  // Latency 1 to 4 cycles
				for (int b = 0; b < LANES; b++) begin
					rd_rng = xorshift(rd_rng);
					repeat (rd_rng % 3) begin
						o_rd_we = 1'b0;  // Gap between beats
						@(negedge clk);
					end
					o_rd_we   = 1'b1;
					o_rd_data = mem[MEM_AW'(int'(base) + b)];
					@(negedge clk);
				end
				o_rd_we = 1'b0;
			end
		end
	end

	initial begin : stall_writes
		o_wr_ready = 1'b0;
		forever begin
			@(negedge clk);
			wr_rng     = xorshift(wr_rng);
			o_wr_ready = (wr_rng % 10) < 6;  // Ready about 60 percent
		end
	end

endmodule

// ==== pool_engine.sv ====
`timescale 1ns/1ps

module pool_engine (
	input  logic                            clk,
	input  logic                            rst,
	// Job port
	input  logic                            i_start,
	input  pool_pkg::pool_op_e              i_op,
	input  logic [pool_pkg::WIN_LOG2_W-1:0] i_win_log2,
	input  logic [pool_pkg::NWIN_W-1:0]     i_num_windows,
	input  pool_pkg::addr_t                 i_src_addr,
	input  pool_pkg::addr_t                 i_dst_addr,
	// DMA read port
	input  pool_pkg::word_t                 i_rd_data,
	input  logic                            i_rd_we,
	output logic                            o_rd_req,
	output pool_pkg::addr_t                 o_rd_addr,
	// DMA write port
	input  logic                            i_wr_ready,
	output logic                            o_wr_valid,
	output pool_pkg::addr_t                 o_wr_addr,
	output pool_pkg::word_t                 o_wr_data,
	// Status
	output logic                            o_busy,
	output logic                            o_done
);

	import pool_pkg::*;

	logic              job_start;   // Accepted job, reducer to fetch
	logic              atom_valid;
	atom_t             atom;        // Assembled atom, fetch to FIFO
	atom_t             head;
	logic              empty;
	logic              pop;
	logic [CNT_W-1:0]  fifo_count;  // Drives fetch read credit

	pool_fetch u_fetch (
		.clk           (clk),
		.rst           (rst),
		.i_job_start   (job_start),
		.i_src_addr    (i_src_addr),
		.i_win_log2    (i_win_log2),
		.i_num_windows (i_num_windows),
		.i_fifo_count  (fifo_count),
		.i_rd_data     (i_rd_data),
		.i_rd_we       (i_rd_we),
		.o_rd_req      (o_rd_req),
		.o_rd_addr     (o_rd_addr),
		.o_atom_valid  (atom_valid),
		.o_atom        (atom)
	);

	atom_fifo u_fifo (
		.clk     (clk),
		.rst     (rst),
		.i_push  (atom_valid),
		.i_atom  (atom),
		.i_pop   (pop),
		.o_head  (head),
		.o_empty (empty),
		.o_count (fifo_count)
	);

	pool_reduce u_reduce (
		.clk           (clk),
		.rst           (rst),
		.i_start       (i_start),
		.i_op          (i_op),
		.i_win_log2    (i_win_log2),
		.i_num_windows (i_num_windows),
		.i_dst_addr    (i_dst_addr),
		.i_head        (head),
		.i_empty       (empty),
		.i_wr_ready    (i_wr_ready),
		.o_job_start   (job_start),
		.o_pop         (pop),
		.o_wr_valid    (o_wr_valid),
		.o_wr_addr     (o_wr_addr),
		.o_wr_data     (o_wr_data),
		.o_busy        (o_busy),
		.o_done        (o_done)
	);

endmodule

// ==== pool_reduce.sv ====
`timescale 1ns/1ps

module pool_reduce (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            i_start,
	input  pool_pkg::pool_op_e              i_op,
	input  logic [pool_pkg::WIN_LOG2_W-1:0] i_win_log2,
	input  logic [pool_pkg::NWIN_W-1:0]     i_num_windows,
	input  pool_pkg::addr_t                 i_dst_addr,
	input  pool_pkg::atom_t                 i_head,
	input  logic                            i_empty,
	input  logic                            i_wr_ready,
	output logic                            o_job_start,
	output logic                            o_pop,
	output logic                            o_wr_valid,
	output pool_pkg::addr_t                 o_wr_addr,
	output pool_pkg::word_t                 o_wr_data,
	output logic                            o_busy,
	output logic                            o_done
);

	import pool_pkg::*;

	reduce_state_e          state;
	pool_op_e               op_q;        // Latched opcode
	logic [WIN_LOG2_W-1:0]  win_q;       // Latched window exponent
	logic [NWIN_W-1:0]      win_left;    // Windows still to produce
	logic [IDX_W-1:0]       atom_idx;    // Position inside the window
	logic [BEAT_W-1:0]      lane_idx;    // Lane being written
	logic [IDX_W:0]         win_len;
	logic                   last_atom;
	logic                   xfer;
	logic                   valid_op;
	logic [SUM_W-1:0]       acc      [LANES];  // Per-lane running max or sum
	logic [SUM_W-1:0]       acc_next [LANES];
	word_t                  res      [LANES];  // Result words of the finished window

	assign valid_op    = (i_op == OP_MPOOL) || (i_op == OP_APOOL);
	assign o_busy      = (state != RED_IDLE);
	// Unknown opcode or empty job never starts
	assign o_job_start = !o_busy && i_start && valid_op && (i_num_windows != '0);

	assign o_pop      = (state == RED_GATHER) && !i_empty;
	assign win_len    = (IDX_W + 1)'(1) << win_q;
	assign last_atom  = (atom_idx == IDX_W'(win_len - 1'b1));
	assign o_wr_valid = (state == RED_WRITE);
	assign o_wr_data  = res[lane_idx];
	assign xfer       = o_wr_valid && i_wr_ready;

	// First atom loads, later ones fold in
	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			if (atom_idx == '0)
				acc_next[l] = SUM_W'(i_head[l]);
			else if (op_q == OP_MPOOL)
				acc_next[l] = (SUM_W'(i_head[l]) > acc[l]) ? SUM_W'(i_head[l]) : acc[l];
			else
				acc_next[l] = acc[l] + SUM_W'(i_head[l]);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= RED_IDLE;
			win_left <= '0;
			atom_idx <= '0;
			lane_idx <= '0;
			o_done   <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
				RED_IDLE: begin
					if (o_job_start) begin
						win_left <= i_num_windows;
						atom_idx <= '0;
						state    <= RED_GATHER;
					end
				end
				RED_GATHER: begin
					if (o_pop) begin
						atom_idx <= last_atom ? '0 : atom_idx + 1'b1;
						if (last_atom) begin
							lane_idx <= '0;
							state    <= RED_WRITE;  // Valid rises after res is loaded
						end
					end
				end
				RED_WRITE: begin
					if (xfer) begin
						lane_idx <= lane_idx + 1'b1;
						if (lane_idx == BEAT_W'(LANES - 1)) begin
							if (win_left == NWIN_W'(1)) begin
								o_done <= 1'b1;  // Busy drops on the same edge
								state  <= RED_IDLE;
							end else begin
								win_left <= win_left - 1'b1;
								state    <= RED_GATHER;
							end
						end
					end
				end
				default: state <= RED_IDLE;
			endcase
		end
	end

	// Job fields, accumulators and write address
	always_ff @(posedge clk) begin
		if (o_job_start) begin
			op_q      <= i_op;
			win_q     <= i_win_log2;
			o_wr_addr <= i_dst_addr;
		end else if (xfer) begin
			o_wr_addr <= o_wr_addr + 1'b1;  // dst + w*LANES + l, lanes in order
		end
		if (o_pop) begin
			for (int l = 0; l < LANES; l++) begin
				acc[l] <= acc_next[l];
				if (last_atom)
					res[l] <= (op_q == OP_MPOOL) ? word_t'(acc_next[l])
					                             : word_t'(acc_next[l] >> win_q);
			end
		end
	end

	// Write port holds its word until the DMA takes it
	a_wr_stable: assert property (@(posedge clk) disable iff (rst)
		o_wr_valid && !i_wr_ready |=> o_wr_valid && $stable(o_wr_data)
		&& $stable(o_wr_addr));

endmodule

// ==== atom_fifo.sv ====
`timescale 1ns/1ps

module atom_fifo (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       i_push,
	input  pool_pkg::atom_t            i_atom,
	input  logic                       i_pop,
	output pool_pkg::atom_t            o_head,
	output logic                       o_empty,
	output logic [pool_pkg::CNT_W-1:0] o_count
);

	import pool_pkg::*;

	atom_t             mem [FIFO_DEPTH];  // Atom storage
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic              full;

	assign o_head  = mem[rd_ptr];  // Head visible the cycle after its push
	assign o_empty = (o_count == '0);
	assign full    = (o_count == CNT_W'(FIFO_DEPTH));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			o_count <= '0;
		end else begin
			if (i_push)
				wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, wraps by itself
			if (i_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({i_push, i_pop})
				2'b10:   o_count <= o_count + 1'b1;
				2'b01:   o_count <= o_count - 1'b1;
				default: o_count <= o_count;  // Both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (i_push)
			mem[wr_ptr] <= i_atom;
	end

	// Fetch credit must keep the buffer from overflowing
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		i_push |-> !full);

	// Reducer only consumes what is there
	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		i_pop |-> !o_empty);

endmodule

// ==== pool_fetch.sv ====
`timescale 1ns/1ps

module pool_fetch (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          i_job_start,
	input  pool_pkg::addr_t               i_src_addr,
	input  logic [pool_pkg::WIN_LOG2_W-1:0] i_win_log2,
	input  logic [pool_pkg::NWIN_W-1:0]   i_num_windows,
	input  logic [pool_pkg::CNT_W-1:0]    i_fifo_count,
	input  pool_pkg::word_t               i_rd_data,
	input  logic                          i_rd_we,
	output logic                          o_rd_req,
	output pool_pkg::addr_t               o_rd_addr,
	output logic                          o_atom_valid,
	output pool_pkg::atom_t               o_atom
);

	import pool_pkg::*;

	fetch_state_e         state;
	logic [ATOMS_W-1:0]   atoms_left;  // Bursts still to request
	addr_t                next_addr;   // Source of the next burst
	logic [BEAT_W-1:0]    beat_cnt;    // Beats received in this burst
	logic [ATOMS_W-1:0]   job_atoms;
	logic [CNT_W-1:0]     fill;
	logic                 credit;
	logic                 last_beat;

	// Atom total is windows times window length
	assign job_atoms = ATOMS_W'(i_num_windows) << i_win_log2;

	// Atom being pushed this cycle is not yet in the FIFO count
	assign fill      = i_fifo_count + CNT_W'(o_atom_valid);
	assign credit    = fill < CNT_W'(FIFO_DEPTH);
	assign last_beat = i_rd_we && (beat_cnt == BEAT_W'(LANES - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state        <= FET_IDLE;
			atoms_left   <= '0;
			beat_cnt     <= '0;
			o_rd_req     <= 1'b0;
			o_atom_valid <= 1'b0;
		end else begin
			o_rd_req     <= 1'b0;  // Both are single-cycle pulses
			o_atom_valid <= 1'b0;
			case (state)
				FET_IDLE: begin
					// FIFO is drained between jobs, so the first burst has room
					if (i_job_start) begin
						o_rd_req   <= 1'b1;
						atoms_left <= job_atoms - 1'b1;
						beat_cnt   <= '0;
						state      <= FET_RECEIVE;
					end
				end
				FET_REQUEST: begin
					if (credit) begin
						o_rd_req   <= 1'b1;
						atoms_left <= atoms_left - 1'b1;
						beat_cnt   <= '0;
						state      <= FET_RECEIVE;
					end
				end
				FET_RECEIVE: begin
					if (i_rd_we)
						beat_cnt <= beat_cnt + 1'b1;
					if (last_beat) begin
						o_atom_valid <= 1'b1;  // Push on the cycle after the last beat
						state        <= (atoms_left == '0) ? FET_IDLE : FET_REQUEST;
					end
				end
				default: state <= FET_IDLE;
			endcase
		end
	end

	// Burst address and deserializer
	always_ff @(posedge clk) begin
		if (state == FET_IDLE && i_job_start) begin
			o_rd_addr <= i_src_addr;
			next_addr <= i_src_addr + ADDR_W'(LANES);
		end else if (state == FET_REQUEST && credit) begin
			o_rd_addr <= next_addr;
			next_addr <= next_addr + ADDR_W'(LANES);  // Data is contiguous
		end
		if (i_rd_we)
			o_atom <= {i_rd_data, o_atom[LANES-1:1]};  // New beat enters at the top
	end

	// Read beats only ever answer an issued burst
	a_beat_in_receive: assert property (@(posedge clk) disable iff (rst)
		i_rd_we |-> state == FET_RECEIVE);

endmodule

// ==== pool_pkg.sv ====
package pool_pkg;

	// Atom geometry
	localparam int LANES      = 4;   // Words per atom, one per channel lane
	localparam int DATA_W     = 16;  // Lane word width
	localparam int ADDR_W     = 30;  // DMA word address width

	// Buffering between fetch and reducer
	localparam int FIFO_DEPTH = 4;                       // Atoms held in the FIFO
	localparam int PTR_W      = $clog2(FIFO_DEPTH);      // Circular pointer width
	localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);  // Fill count, 0..FIFO_DEPTH

	// Job geometry
	localparam int WIN_LOG2_W = 2;  // Window exponent width, 0..3
	localparam int NWIN_W     = 8;  // Window count width
	localparam int MAX_LOG2   = (1 << WIN_LOG2_W) - 1;  // Largest window exponent
	localparam int IDX_W      = MAX_LOG2;               // Atom index inside a window
	localparam int ATOMS_W    = NWIN_W + MAX_LOG2;      // Atoms per job
	localparam int BEAT_W     = $clog2(LANES);          // Beat / lane index

	// Sum of up to 8 words needs 3 extra bits
	localparam int SUM_W      = DATA_W + MAX_LOG2;

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// Lane 0 holds the first beat of a burst
	typedef word_t [LANES-1:0] atom_t;

	// Command numbers kept from the engine command set
	typedef enum logic [2:0] {
		OP_MPOOL = 3'd4,  // Max pooling
		OP_APOOL = 3'd5   // Average pooling
	} pool_op_e;

	typedef enum logic [1:0] {
		RED_IDLE,    // Waiting for a job
		RED_GATHER,  // Popping atoms of the current window
		RED_WRITE    // Streaming result lanes to the write port
	} reduce_state_e;

	typedef enum logic [1:0] {
		FET_IDLE,     // No job
		FET_REQUEST,  // Waiting for FIFO room
		FET_RECEIVE   // Burst outstanding, collecting beats
	} fetch_state_e;

endpackage
